/* tests/pipeline_trace.txt */
# P addr word: program doubleword, instruction at addr+4 in the upper half
# C idx data wr_en: expected commit in order, data unchecked when wr_en is 0; S code ends a section
P 00000000 ffd0011300500093
P 00000008 6781e213123451b7
P 00000010 0f027313fff24293
P 00000018 40208433002083b3
P 00000020 00736533005274b3
P 00000028 0010063300708013
P 00000030 02d68733022086b3
P 00000038 0210803302228833
P 00000040 00e88933030408b3
P 00000048 0010099310500073
C 01 00000005 1 # addi x1, x0, 5
C 02 fffffffd 1 # addi x2, x0, -3
C 03 12345000 1 # lui x3, 0x12345
C 04 12345678 1 # ori x4, x3, 0x678
C 05 edcba987 1 # xori x5, x4, -1
C 06 00000070 1 # andi x6, x4, 0xf0
C 07 00000002 1 # add x7, x1, x2
C 08 00000008 1 # sub x8, x1, x2
C 09 00000000 1 # and x9, x4, x5
C 0a 00000072 1 # or x10, x6, x7
C 00 00000000 0 # addi x0, x1, 7
C 0c 00000005 1 # add x12, x0, x1
C 0d fffffff1 1 # mul x13, x1, x2
C 0e 000000e1 1 # mul x14, x13, x13
C 10 369d036b 1 # mul x16, x5, x2
C 00 00000000 0 # mul x0, x1, x1
C 11 b4e81b58 1 # mul x17, x8, x16
C 12 b4e81c39 1 # add x18, x17, x14
C 00 00000000 0 # wfi, the addi x19 after it never commits
S e
P 00000000 0020a1b300900093
P 00000008 0010019300100113
C 01 00000009 1 # addi x1, x0, 9
C 00 00000000 0 # slt x3, x1, x2 is not supported
S 2

/* verisimple.f */
source/verisimple_pkg.sv
source/fetch_stage.sv
source/inst_queue.sv
source/mul_unit.sv
source/exec_stage.sv
source/pipeline.sv
tests/pipeline_tb.sv

/* Makefile */
# Verilator build and run of the pipeline testbench

SRCS := $(shell cat verisimple.f)

.PHONY: all run clean

all: run

obj_dir/Vpipeline_tb: $(SRCS) verisimple.f
	verilator --binary --assert -j 0 --top-module pipeline_tb -f verisimple.f

run: obj_dir/Vpipeline_tb
	./obj_dir/Vpipeline_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "sim passed" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* tests/pipeline_tb.sv */
// testbench for pipeline with trace loader, latency-randomized memory model and commit checks
`timescale 1ns/1ps
`default_nettype none

module pipeline_tb;

	localparam int                    IQ_DEPTH = 4;
	localparam verisimple_pkg::xlen_t RESET_PC = 32'h0;
	// cycle limit per awaited commit
	localparam int COMMIT_LIMIT = 100;
	// silent tail after the last expected commit
	localparam int QUIET_CYCLES = 50;
	// addi x0, x0, 0 for addresses outside the program
	localparam logic [31:0] NOP_WORD = 32'h0000_0013;

	logic                             clock = 1'b0;
	logic                             reset = 1'b1;
	logic                             mem2proc_valid = 1'b0;
	verisimple_pkg::mem_word_t        mem2proc_data = '0;
	verisimple_pkg::bus_cmd_t         proc2mem_command;
	verisimple_pkg::xlen_t            proc2mem_addr;
	logic [3:0]                       pipeline_completed_insts;
	verisimple_pkg::exception_code_t  pipeline_error_status;
	verisimple_pkg::reg_idx_t         pipeline_commit_wr_idx;
	verisimple_pkg::xlen_t            pipeline_commit_wr_data;
	logic                             pipeline_commit_wr_en;
	verisimple_pkg::xlen_t            pipeline_commit_NPC;

	// trace contents, tagged with their section
	int                              prog_sec [$];
	verisimple_pkg::xlen_t           prog_addr [$];
	verisimple_pkg::mem_word_t       prog_word [$];
	int                              exp_sec [$];
	verisimple_pkg::reg_idx_t        exp_idx [$];
	verisimple_pkg::xlen_t           exp_data [$];
	logic                            exp_en [$];
	verisimple_pkg::exception_code_t exp_status [$];

	// sparse program image of the running section
	verisimple_pkg::mem_word_t prog_mem [verisimple_pkg::xlen_t];

	// memory model state
	logic [31:0] rng_state = 32'h60143aad;
	logic [1:0]  wait_left = 2'd0;
	logic        counting = 1'b0;

	pipeline #(.IQ_DEPTH(IQ_DEPTH), .RESET_PC(RESET_PC)) uut (
		.clock                    (clock),
		.reset                    (reset),
		.mem2proc_valid           (mem2proc_valid),
		.mem2proc_data            (mem2proc_data),
		.proc2mem_command         (proc2mem_command),
		.proc2mem_addr            (proc2mem_addr),
		.pipeline_completed_insts (pipeline_completed_insts),
		.pipeline_error_status    (pipeline_error_status),
		.pipeline_commit_wr_idx   (pipeline_commit_wr_idx),
		.pipeline_commit_wr_data  (pipeline_commit_wr_data),
		.pipeline_commit_wr_en    (pipeline_commit_wr_en),
		.pipeline_commit_NPC      (pipeline_commit_NPC)
	);

	// 20 ns period
	always #10 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// unwritten doublewords hold two nops
	function automatic verisimple_pkg::mem_word_t read_word(input verisimple_pkg::xlen_t addr);
		if (prog_mem.exists(addr))
			return prog_mem[addr];
		return {NOP_WORD, NOP_WORD};
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_commit(input string name, input verisimple_pkg::reg_idx_t idx,
			input verisimple_pkg::xlen_t data, input logic en);
		// one retire per cycle at most
		if (pipeline_completed_insts !== 4'd1)
			stop_on_error($sformatf("ERR %s completed_insts expected %0d actual %0d",
				name, 4'd1, pipeline_completed_insts));
		else if (pipeline_commit_wr_en !== en)
			stop_on_error($sformatf("ERR %s wr_en expected %0b actual %0b",
				name, en, pipeline_commit_wr_en));
		else if (pipeline_commit_wr_idx !== idx)
			stop_on_error($sformatf("ERR %s wr_idx expected %0d actual %0d",
				name, idx, pipeline_commit_wr_idx));
		// data only matters when the register is written
		else if (en && pipeline_commit_wr_data !== data)
			stop_on_error($sformatf("ERR %s wr_data expected %h actual %h",
				name, data, pipeline_commit_wr_data));
	endtask

	task automatic check_npc(input string name, input verisimple_pkg::xlen_t npc);
		if (pipeline_commit_NPC !== npc)
			stop_on_error($sformatf("ERR %s npc expected %h actual %h",
				name, npc, pipeline_commit_NPC));
	endtask

	task automatic check_status(input string name, input verisimple_pkg::exception_code_t code);
		if (pipeline_error_status !== code)
			stop_on_error($sformatf("ERR %s status expected %h actual %h",
				name, code, pipeline_error_status));
	endtask

	task automatic check_bus_cmd(input string name, input verisimple_pkg::bus_cmd_t cmd);
		if (proc2mem_command !== cmd)
			stop_on_error($sformatf("ERR %s command expected %h actual %h",
				name, cmd, proc2mem_command));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("ERR %s expected %0b actual %0b", name, exp, act));
	endtask

	//////////////////////////////////////////////////////////////////////
	// memory model, one load at a time, 0 to 3 cycles extra latency
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (reset) begin
			mem2proc_valid <= 1'b0;
			counting       <= 1'b0;
		end else if (mem2proc_valid) begin
			// pulse lasts one cycle
			mem2proc_valid <= 1'b0;
		end else if (proc2mem_command == verisimple_pkg::BUS_LOAD) begin
			if (proc2mem_addr[2:0] != 3'b000)
				stop_on_error("fetch issued an address that is not doubleword aligned");
			if (counting && wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else if (!counting) begin
				rng_state = next_random(rng_state);
				if (rng_state[1:0] == 2'd0) begin
					mem2proc_valid <= 1'b1;
					mem2proc_data  <= read_word(proc2mem_addr);
				end else begin
					counting  <= 1'b1;
					wait_left <= rng_state[1:0] - 2'd1;
				end
			end else begin
				counting       <= 1'b0;
				mem2proc_valid <= 1'b1;
				mem2proc_data  <= read_word(proc2mem_addr);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// trace and sections
	//////////////////////////////////////////////////////////////////////

	task automatic load_trace();
		int fd;
		int sec;
		int got;
		string line;
		byte kind;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		fd = $fopen("tests/pipeline_trace.txt", "r");
		if (fd == 0)
			stop_on_error("could not open the trace file tests/pipeline_trace.txt");
		sec = 0;
		while (!$feof(fd)) begin
			line = "";
			got = $fgets(line, fd);
			// blank lines and # comments fall through
			if (got > 1) begin
				kind = line[0];
				got = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
				case (kind)
					"P": begin
						prog_sec.push_back(sec);
						prog_addr.push_back(a[31:0]);
						prog_word.push_back(b);
					end
					"C": begin
						exp_sec.push_back(sec);
						exp_idx.push_back(a[4:0]);
						exp_data.push_back(b[31:0]);
						exp_en.push_back(c[0]);
					end
					"S": begin
						exp_status.push_back(a[3:0]);
						sec++;
					end
					default: ;
				endcase
			end
		end
		$fclose(fd);
		if (exp_status.size() == 0)
			stop_on_error("the trace file holds no section");
	endtask

	// commit strobe lasts one cycle, sampled mid-cycle
	task automatic wait_commit(input string what);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!pipeline_completed_insts[0] && cycles < COMMIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (!pipeline_completed_insts[0])
			stop_on_error($sformatf("timeout, %s never arrived", what));
	endtask

	task automatic expect_quiet(input int sec);
		int cycles;
		for (cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
			@(negedge clock);
			if (pipeline_completed_insts[0])
				stop_on_error($sformatf("section %0d retired an instruction after its last one",
					sec));
		end
	endtask

	task automatic run_section(input int sec);
		int i;
		int k;
		string tag;
		verisimple_pkg::xlen_t npc;
		@(posedge clock);
		reset <= 1'b1;
		// fresh program image for this section
		prog_mem.delete();
		for (i = 0; i < prog_sec.size(); i++) begin
			if (prog_sec[i] == sec)
				prog_mem[prog_addr[i]] = prog_word[i];
		end
		repeat (9) @(posedge clock);
		@(negedge clock);
		check_bus_cmd("reset", verisimple_pkg::BUS_NONE);
		check_flag("reset completed strobe", 1'b0, pipeline_completed_insts[0]);
		check_flag("reset wr_en", 1'b0, pipeline_commit_wr_en);
		check_status("reset", verisimple_pkg::NO_ERROR);
		@(posedge clock);
		reset <= 1'b0;
		npc = RESET_PC;
		k = 0;
		// commits in program order, npc steps by 4
		for (i = 0; i < exp_idx.size(); i++) begin
			if (exp_sec[i] == sec) begin
				tag = $sformatf("section %0d commit %0d", sec, k);
				wait_commit(tag);
				check_commit(tag, exp_idx[i], exp_data[i], exp_en[i]);
				npc = npc + 32'd4;
				check_npc(tag, npc);
				k++;
			end
		end
		expect_quiet(sec);
		check_status($sformatf("section %0d final", sec), exp_status[sec]);
		// halted core, full queue, idle bus
		repeat (5) begin
			@(negedge clock);
			check_bus_cmd($sformatf("section %0d stalled fetch", sec), verisimple_pkg::BUS_NONE);
		end
	endtask

	initial begin
		load_trace();
		for (int s = 0; s < exp_status.size(); s++)
			run_section(s);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* source/pipeline.sv */
// top level joining fetch, instruction queue and execute, memory and commit ports
`timescale 1ns/1ps
`default_nettype none

module pipeline #(
	parameter int                    IQ_DEPTH = 4,
	parameter verisimple_pkg::xlen_t RESET_PC = 32'h0
) (
	input  wire                              clock,
	input  wire                              reset,
	input  wire                              mem2proc_valid,
	input  wire verisimple_pkg::mem_word_t   mem2proc_data,
	output verisimple_pkg::bus_cmd_t         proc2mem_command,
	output verisimple_pkg::xlen_t            proc2mem_addr,
	output logic [3:0]                       pipeline_completed_insts,
	output verisimple_pkg::exception_code_t  pipeline_error_status,
	output verisimple_pkg::reg_idx_t         pipeline_commit_wr_idx,
	output verisimple_pkg::xlen_t            pipeline_commit_wr_data,
	output logic                             pipeline_commit_wr_en,
	output verisimple_pkg::xlen_t            pipeline_commit_NPC
);

	// fetch to queue
	logic                  push;
	verisimple_pkg::inst_t push_inst;
	verisimple_pkg::xlen_t push_pc;
	logic                  full;

	// queue to execute
	verisimple_pkg::inst_t head_inst;
	verisimple_pkg::xlen_t head_pc;
	logic                  empty;
	logic                  pop;
	logic                  completed;

	// at most one retire per cycle
	assign pipeline_completed_insts = {3'b000, completed};

	//////////////////////////////////////////////////////////////////////
	// stages
	//////////////////////////////////////////////////////////////////////

	fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_0 (
		.clock            (clock),
		.reset            (reset),
		.mem2proc_valid   (mem2proc_valid),
		.mem2proc_data    (mem2proc_data),
		.full             (full),
		.proc2mem_command (proc2mem_command),
		.proc2mem_addr    (proc2mem_addr),
		.push             (push),
		.push_inst        (push_inst),
		.push_pc          (push_pc)
	);

	inst_queue #(.IQ_DEPTH(IQ_DEPTH)) inst_queue_0 (
		.clock     (clock),
		.reset     (reset),
		.push      (push),
		.push_inst (push_inst),
		.push_pc   (push_pc),
		.pop       (pop),
		.head_inst (head_inst),
		.head_pc   (head_pc),
		.full      (full),
		.empty     (empty)
	);

	exec_stage exec_stage_0 (
		.clock          (clock),
		.reset          (reset),
		.head_inst      (head_inst),
		.head_pc        (head_pc),
		.empty          (empty),
		.pop            (pop),
		.completed      (completed),
		.commit_wr_en   (pipeline_commit_wr_en),
		.commit_wr_idx  (pipeline_commit_wr_idx),
		.commit_wr_data (pipeline_commit_wr_data),
		.commit_npc     (pipeline_commit_NPC),
		.error_status   (pipeline_error_status)
	);

endmodule

`default_nettype wire

/* source/exec_stage.sv */
// execute and retire stage with decoder, register file, alu, halt fsm, commit outputs
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
	input  wire                                clock,
	input  wire                                reset,
	input  wire verisimple_pkg::inst_t         head_inst,
	input  wire verisimple_pkg::xlen_t         head_pc,
	input  wire                                empty,
	output logic                               pop,
	output logic                               completed,
	output logic                               commit_wr_en,
	output verisimple_pkg::reg_idx_t           commit_wr_idx,
	output verisimple_pkg::xlen_t              commit_wr_data,
	output verisimple_pkg::xlen_t              commit_npc,
	output verisimple_pkg::exception_code_t    error_status
);

	typedef enum logic [1:0] {RUN, MUL_WAIT, HALTED} exec_state_t;

	exec_state_t state;
	verisimple_pkg::xlen_t regfile [32];

	// instruction fields
	verisimple_pkg::opcode_t  opcode;
	verisimple_pkg::funct3_t  funct3;
	verisimple_pkg::funct7_t  funct7;
	verisimple_pkg::reg_idx_t rd;
	verisimple_pkg::reg_idx_t rs1;
	verisimple_pkg::reg_idx_t rs2;
	verisimple_pkg::xlen_t    rs1_val;
	verisimple_pkg::xlen_t    rs2_val;
	verisimple_pkg::xlen_t    opnd_b;
	verisimple_pkg::xlen_t    alu_result;
	logic legal;
	logic is_mul;
	logic is_wfi;
	logic basic_f3;

	// register file write port
	logic                     rf_we;
	verisimple_pkg::reg_idx_t rf_waddr;
	verisimple_pkg::xlen_t    rf_wdata;

	// multiplier hookup
	logic                  mul_start;
	logic                  mul_done;
	verisimple_pkg::xlen_t mul_a;
	verisimple_pkg::xlen_t mul_b;
	verisimple_pkg::xlen_t mul_product;

	assign opcode = head_inst[6:0];
	assign rd     = head_inst[11:7];
	assign funct3 = head_inst[14:12];
	assign rs1    = head_inst[19:15];
	assign rs2    = head_inst[24:20];
	assign funct7 = head_inst[31:25];
	assign is_wfi = (head_inst == verisimple_pkg::WFI_INST);

	// x0 reads as zero, its entry is never written
	assign rs1_val = (rs1 == '0) ? '0 : regfile[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : regfile[rs2];

	// only the head is consumed, and only while running
	assign pop = (state == RUN) && !empty;

	//////////////////////////////////////////////////////////////////////
	// decode and alu
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		basic_f3 = (funct3 == verisimple_pkg::F3_ADD) || (funct3 == verisimple_pkg::F3_XOR) ||
		           (funct3 == verisimple_pkg::F3_OR) || (funct3 == verisimple_pkg::F3_AND);
		legal  = 1'b0;
		is_mul = 1'b0;
		opnd_b = rs2_val;
		case (opcode)
			verisimple_pkg::OP_IMM: begin
				legal  = basic_f3;
				// sign extended 12 bit immediate
				opnd_b = {{20{head_inst[31]}}, head_inst[31:20]};
			end
			verisimple_pkg::OP_REG: begin
				if (funct7 == verisimple_pkg::F7_MUL) begin
					legal  = (funct3 == verisimple_pkg::F3_MUL);
					is_mul = legal;
				end else if (funct7 == verisimple_pkg::F7_SUB)
					legal = (funct3 == verisimple_pkg::F3_ADD);
				else
					legal = (funct7 == verisimple_pkg::F7_BASE) && basic_f3;
			end
			verisimple_pkg::OP_LUI:
				legal = 1'b1;
			default:
				legal = 1'b0;
		endcase

		case (funct3)
			verisimple_pkg::F3_XOR: alu_result = rs1_val ^ opnd_b;
			verisimple_pkg::F3_OR:  alu_result = rs1_val | opnd_b;
			verisimple_pkg::F3_AND: alu_result = rs1_val & opnd_b;
			default: begin
				// add, or sub for the register form with funct7 set
				if (opcode == verisimple_pkg::OP_REG && funct7 == verisimple_pkg::F7_SUB)
					alu_result = rs1_val - opnd_b;
				else
					alu_result = rs1_val + opnd_b;
			end
		endcase
		// lui ignores the alu, upper immediate only
		if (opcode == verisimple_pkg::OP_LUI)
			alu_result = {head_inst[31:12], 12'b0};
	end

	// multiply result lands at the index held since the pop
	always_comb begin
		if (state == MUL_WAIT && mul_done) begin
			rf_we    = (commit_wr_idx != '0);
			rf_waddr = commit_wr_idx;
			rf_wdata = mul_product;
		end else begin
			rf_we    = pop && legal && !is_mul && (rd != '0);
			rf_waddr = rd;
			rf_wdata = alu_result;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// state machine and commit strobes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state        <= RUN;
			completed    <= 1'b0;
			commit_wr_en <= 1'b0;
			error_status <= verisimple_pkg::NO_ERROR;
			mul_start    <= 1'b0;
		end else begin
			completed    <= 1'b0;
			commit_wr_en <= rf_we;
			mul_start    <= 1'b0;
			case (state)
				RUN: begin
					if (pop && is_mul) begin
						mul_start <= 1'b1;
						state     <= MUL_WAIT;
					end else if (pop) begin
						completed <= 1'b1;
						// wfi and unknown encodings stop the core for good
						if (!legal) begin
							state        <= HALTED;
							error_status <= is_wfi ? verisimple_pkg::HALTED_ON_WFI
							                       : verisimple_pkg::ILLEGAL_INST;
						end
					end
				end
				MUL_WAIT: begin
					if (mul_done) begin
						completed <= 1'b1;
						state     <= RUN;
					end
				end
				default: state <= HALTED;
			endcase
		end
	end

	// commit payload, idx and npc also serve as the pending multiply's tag
	always_ff @(posedge clock) begin
		if (pop) begin
			commit_npc     <= head_pc + 32'd4;
			commit_wr_idx  <= legal ? rd : '0;
			commit_wr_data <= legal ? alu_result : '0;
			mul_a          <= rs1_val;
			mul_b          <= rs2_val;
		end else if (state == MUL_WAIT && mul_done) begin
			commit_wr_data <= mul_product;
		end
		if (rf_we)
			regfile[rf_waddr] <= rf_wdata;
	end

	mul_unit mul_unit_0 (
		.clock        (clock),
		.reset        (reset),
		.start        (mul_start),
		.multiplicand (mul_a),
		.multiplier   (mul_b),
		.done         (mul_done),
		.product      (mul_product)
	);

	// after a halt commit nothing else retires and the status sticks
	a_halt_final: assert property (
		@(posedge clock) disable iff (reset)
		(error_status != verisimple_pkg::NO_ERROR) |=> (!completed && $stable(error_status))
	);

endmodule

`default_nettype wire

/* source/mul_unit.sv */
// iterative shift-add multiplier, 8 multiplier bits per cycle, low 32 bits kept
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          start,
	input  wire verisimple_pkg::xlen_t   multiplicand,
	input  wire verisimple_pkg::xlen_t   multiplier,
	output logic                         done,
	output verisimple_pkg::xlen_t        product
);

	// running sum and operands shifted by one byte per step
	verisimple_pkg::xlen_t acc;
	verisimple_pkg::xlen_t mcand;
	verisimple_pkg::xlen_t mplier;
	logic                  busy;
	logic [1:0]            step;

	// operands of the current step, fresh inputs on start
	verisimple_pkg::xlen_t op_a;
	verisimple_pkg::xlen_t op_b_full;
	verisimple_pkg::xlen_t partial;

	assign op_a      = busy ? mcand : multiplicand;
	assign op_b_full = busy ? mplier : multiplier;
	assign product   = acc;

	// add the shifted multiplicand for each set bit of the low byte
	always_comb begin
		partial = busy ? acc : '0;
		for (int i = 0; i < 8; i++) begin
			if (op_b_full[i])
				partial = partial + (op_a << i);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			step <= 2'd0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				// first byte handled on the start edge
				busy <= 1'b1;
				step <= 2'd1;
			end else if (busy) begin
				step <= step + 2'd1;
				if (step == 2'd3) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start || busy) begin
			acc    <= partial;
			mcand  <= op_a << 8;
			mplier <= op_b_full >> 8;
		end
	end

	// one multiply at a time
	a_start_when_idle: assert property (
		@(posedge clock) disable iff (reset) start |-> !busy
	);

endmodule

`default_nettype wire

/* source/inst_queue.sv */
// circular instruction queue with pc per entry, registered full and empty
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
	parameter int IQ_DEPTH = 4
) (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          push,
	input  wire verisimple_pkg::inst_t   push_inst,
	input  wire verisimple_pkg::xlen_t   push_pc,
	input  wire                          pop,
	output verisimple_pkg::inst_t        head_inst,
	output verisimple_pkg::xlen_t        head_pc,
	output logic                         full,
	output logic                         empty
);

	localparam int PTR_W = $clog2(IQ_DEPTH);

	// entry storage
	verisimple_pkg::inst_t inst_mem [IQ_DEPTH];
	verisimple_pkg::xlen_t pc_mem [IQ_DEPTH];

	// pointers wrap on their own, depth is a power of two
	logic [PTR_W-1:0] head_ptr;
	logic [PTR_W-1:0] tail_ptr;
	// one extra bit to tell full from empty
	logic [PTR_W:0] count;
	logic [PTR_W:0] count_next;

	assign count_next = count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};

	// oldest entry, meaningful while empty is low
	assign head_inst = inst_mem[head_ptr];
	assign head_pc   = pc_mem[head_ptr];

	//////////////////////////////////////////////////////////////////////
	// pointers and flags
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
			full     <= 1'b0;
			empty    <= 1'b1;
		end else begin
			if (push)
				tail_ptr <= tail_ptr + 1'b1;
			if (pop)
				head_ptr <= head_ptr + 1'b1;
			count <= count_next;
			full  <= (count_next == (PTR_W+1)'(IQ_DEPTH));
			empty <= (count_next == '0);
		end
	end

	// storage starts out as nops
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < IQ_DEPTH; i++) begin
				inst_mem[i] <= verisimple_pkg::NOP_INST;
				pc_mem[i]   <= '0;
			end
		end else if (push) begin
			inst_mem[tail_ptr] <= push_inst;
			pc_mem[tail_ptr]   <= push_pc;
		end
	end

	// fetch must respect full
	a_no_overflow: assert property (
		@(posedge clock) disable iff (reset) push |-> !full
	);

	// execute must respect empty
	a_no_underflow: assert property (
		@(posedge clock) disable iff (reset) pop |-> !empty
	);

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
// fetch stage with pc, single outstanding memory load, halfword select, queue push
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter verisimple_pkg::xlen_t RESET_PC = 32'h0
) (
	input  wire                               clock,
	input  wire                               reset,
	input  wire                               mem2proc_valid,
	input  wire verisimple_pkg::mem_word_t    mem2proc_data,
	input  wire                               full,
	output verisimple_pkg::bus_cmd_t          proc2mem_command,
	output verisimple_pkg::xlen_t             proc2mem_addr,
	output logic                              push,
	output verisimple_pkg::inst_t             push_inst,
	output verisimple_pkg::xlen_t             push_pc
);

	// address of the next instruction to fetch
	verisimple_pkg::xlen_t pc;
	// load raised, waiting for the valid pulse
	logic pending;

	// command follows the pending flag, so it is held until memory answers
	assign proc2mem_command = pending ? verisimple_pkg::BUS_LOAD : verisimple_pkg::BUS_NONE;
	// doubleword aligned address
	assign proc2mem_addr = {pc[verisimple_pkg::XLEN-1:3], 3'b000};

	//////////////////////////////////////////////////////////////////////
	// request control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pc      <= RESET_PC;
			pending <= 1'b0;
			push    <= 1'b0;
		end else begin
			push <= 1'b0;
			if (pending && mem2proc_valid) begin
				// answer in, hand it to the queue
				pending <= 1'b0;
				push    <= 1'b1;
				pc      <= pc + 32'd4;
			end else if (!pending && !push && !full) begin
				// wait out the push cycle so full is current
				pending <= 1'b1;
			end
		end
	end

	// returned word, pick the half addressed by pc bit 2
	always_ff @(posedge clock) begin
		if (mem2proc_valid) begin
			push_inst <= pc[2] ? mem2proc_data[63:32] : mem2proc_data[31:0];
			push_pc   <= pc;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus protocol checks
	//////////////////////////////////////////////////////////////////////

	// memory only answers a raised load
	a_valid_needs_request: assert property (
		@(posedge clock) disable iff (reset)
		mem2proc_valid |-> pending
	);

endmodule

`default_nettype wire

/* source/verisimple_pkg.sv */
// shared widths, bus commands, status codes and rv32 decode constants
`default_nettype none

package verisimple_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and value types
	//////////////////////////////////////////////////////////////////////

	localparam int XLEN = 32;

	// one register or pc value
	typedef logic [XLEN-1:0] xlen_t;
	// one fetched instruction
	typedef logic [31:0] inst_t;
	// architectural register index
	typedef logic [4:0] reg_idx_t;
	// memory returns doublewords
	typedef logic [63:0] mem_word_t;

	// instruction fields
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	//////////////////////////////////////////////////////////////////////
	// memory bus commands
	//////////////////////////////////////////////////////////////////////

	typedef logic [1:0] bus_cmd_t;

	localparam bus_cmd_t BUS_NONE = 2'h0;
	localparam bus_cmd_t BUS_LOAD = 2'h1;

	//////////////////////////////////////////////////////////////////////
	// pipeline status, riscv mcause numbering plus two reserved codes
	//////////////////////////////////////////////////////////////////////

	typedef logic [3:0] exception_code_t;

	localparam exception_code_t ILLEGAL_INST  = 4'h2;
	localparam exception_code_t NO_ERROR      = 4'ha;
	localparam exception_code_t HALTED_ON_WFI = 4'he;

	// addi x0, x0, 0
	localparam inst_t NOP_INST = 32'h0000_0013;
	// wfi, stops the core
	localparam inst_t WFI_INST = 32'h1050_0073;

	// major opcodes
	localparam opcode_t OP_IMM = 7'b0010011;
	localparam opcode_t OP_REG = 7'b0110011;
	localparam opcode_t OP_LUI = 7'b0110111;

	// funct3 selects
	localparam funct3_t F3_ADD = 3'b000;
	localparam funct3_t F3_XOR = 3'b100;
	localparam funct3_t F3_OR  = 3'b110;
	localparam funct3_t F3_AND = 3'b111;
	localparam funct3_t F3_MUL = 3'b000;

	// funct7 selects for register ops
	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_SUB  = 7'b0100000;
	localparam funct7_t F7_MUL  = 7'b0000001;

endpackage

`default_nettype wire
